//--- rtl/hps_bus_pkg.sv
// Host bus definitions for command codes, frame kinds and framed word records
package hps_bus_pkg;

	// command codes carried in word 0 of a frame
	localparam logic [15:0] cmd_cfg        = 16'h0001;
	localparam logic [15:0] cmd_joy0       = 16'h0002;
	localparam logic [15:0] cmd_joy1       = 16'h0003;
	localparam logic [15:0] cmd_joy2       = 16'h0010;
	localparam logic [15:0] cmd_joy3       = 16'h0011;
	localparam logic [15:0] cmd_analog_l   = 16'h001a;
	localparam logic [15:0] cmd_status     = 16'h001e;
	localparam logic [15:0] cmd_status_req = 16'h0029;
	localparam logic [15:0] cmd_file_tx    = 16'h0053;
	localparam logic [15:0] cmd_file_dat   = 16'h0054;
	localparam logic [15:0] cmd_file_index = 16'h0055;
	localparam logic [15:0] cmd_file_info  = 16'h0056;

	// word number within a frame that saturates at 63
	typedef logic [5:0] word_idx_t;

	typedef enum logic {
		kind_user,
		kind_file
	} frame_kind_t;

	// analog command reads word 1 as indices and word 2 as axes
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [7:0] spare;
			logic [3:0] paddle_idx;
			logic [3:0] stick_idx;
		} sel;
		struct packed {
			logic [7:0] axis_y;
			logic [7:0] axis_x;
		} axis;
	} host_word_u;

	typedef struct packed {
		logic        valid;
		frame_kind_t kind;
		word_idx_t   idx;
		logic [15:0] cmd;
		host_word_u  data;
	} host_word_t;

endpackage

//--- rtl/hps_user_pkg.sv
// Core side record types for player state, configuration and file writes
package hps_user_pkg;

	localparam int num_players = 4;

	// analog holds Y in the upper byte and X in the lower byte
	typedef struct packed {
		logic [31:0] digital;
		logic [15:0] analog;
		logic [7:0]  paddle;
	} player_t;

	typedef player_t [num_players-1:0] player_arr_t;

	typedef struct packed {
		logic [1:0] buttons;
		logic       forced_scandoubler;
		logic       direct_video;
	} core_cfg_t;

	// narrow mode leaves the upper byte of dout at zero
	typedef struct packed {
		logic        wr;
		logic [26:0] addr;
		logic [15:0] dout;
	} file_write_t;

endpackage

//--- rtl/hps_word_framer.sv
// Host word framer that numbers strobed words and latches each command
`timescale 1ns/1ps

module hps_word_framer
	import hps_bus_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        io_enable,
	input  logic        fp_enable,
	input  logic        io_strobe,
	input  logic [15:0] io_din,
	output host_word_t  word
);

	logic      in_frame;
	word_idx_t cnt;

	// either enable level opens a frame
	assign in_frame = io_enable | fp_enable;

	//////////////////////////////////////////////////
	// word record register
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			word <= '0;
			cnt  <= '0;
		end else if (!in_frame) begin
			// idle between frames so the next one restarts at word 0
			word <= '0;
			cnt  <= '0;
		end else begin
			word.valid <= io_strobe;
			if (io_strobe) begin
				word.kind     <= fp_enable ? kind_file : kind_user;
				word.idx      <= cnt;
				word.data.raw <= io_din;

				// command latched on word 0 and held for the frame
				if (cnt == '0) begin
					word.cmd <= io_din;
				end

				// stop counting at the top
				if (cnt != '1) begin
					cnt <= cnt + 6'd1;
				end
			end
		end
	end

endmodule

//--- rtl/hps_user_regs.sv
// User command decoder holding settings, controllers, status and readback
`timescale 1ns/1ps

module hps_user_regs
	import hps_bus_pkg::*;
	import hps_user_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  host_word_t  word,
	input  logic [63:0] status_in,
	input  logic        status_set,
	output core_cfg_t   cfg,
	output player_arr_t players,
	output logic [63:0] status,
	output logic [15:0] io_dout
);

	logic        user_rec;
	logic        readback_live;
	logic        set_edge;
	logic        old_status_set;
	logic [3:0]  req_cnt;
	logic [63:0] status_req;
	host_word_u  sel_q;
	logic        joy_hit;
	logic [1:0]  joy_sel;

	assign user_rec      = word.valid && (word.kind == kind_user);
	assign readback_live = (word.kind == kind_user) && (word.cmd == cmd_status_req);
	assign set_edge      = status_set && !old_status_set;

	// joystick command to player number
	always_comb begin
		joy_hit = 1'b1;
		joy_sel = 2'd0;
		case (word.cmd)
			cmd_joy0: joy_sel = 2'd0;
			cmd_joy1: joy_sel = 2'd1;
			cmd_joy2: joy_sel = 2'd2;
			cmd_joy3: joy_sel = 2'd3;
			default:  joy_hit = 1'b0;
		endcase
	end

	// latched request and analog indices
	always_ff @(posedge clk_sys) begin
		if (set_edge) begin
			status_req <= status_in;
		end
		if (user_rec && word.cmd == cmd_analog_l && word.idx == 6'd1) begin
			sel_q <= word.data;
		end
	end

	//////////////////////////////////////////////////
	// command decode
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cfg            <= '0;
			players        <= '0;
			status         <= '0;
			io_dout        <= '0;
			old_status_set <= 1'b0;
			req_cnt        <= '0;
		end else begin
			old_status_set <= status_set;
			if (set_edge) begin
				req_cnt <= req_cnt + 4'd1;
			end

			if (user_rec) begin
				io_dout <= '0;
				if (word.idx == '0) begin
					if (word.cmd == cmd_status_req) begin
						io_dout <= {8'h00, 4'hA, req_cnt};
					end
				end else if (joy_hit) begin
					if (word.idx == 6'd1) begin
						players[joy_sel].digital[15:0] <= word.data.raw;
					end else begin
						players[joy_sel].digital[31:16] <= word.data.raw;
					end
				end else begin
					case (word.cmd)
						cmd_cfg: begin
							cfg.buttons            <= word.data.raw[1:0];
							cfg.forced_scandoubler <= word.data.raw[4];
							cfg.direct_video       <= word.data.raw[10];
						end
						cmd_analog_l: begin
							if (word.idx == 6'd2) begin
								if (sel_q.sel.stick_idx < num_players) begin
									players[sel_q.sel.stick_idx[1:0]].analog <= word.data.raw;
								end else if (sel_q.sel.stick_idx == 4'hf &&
								             sel_q.sel.paddle_idx < num_players) begin
									players[sel_q.sel.paddle_idx[1:0]].paddle <=
										word.data.axis.axis_x;
								end
							end
						end
						cmd_status: begin
							if (word.idx <= 6'd4) begin
								status[(word.idx - 6'd1) * 16 +: 16] <= word.data.raw;
							end
						end
						cmd_status_req: begin
							if (word.idx <= 6'd4) begin
								io_dout <= status_req[(word.idx - 6'd1) * 16 +: 16];
							end
						end
						default: ;
					endcase
				end
			end else if (!readback_live) begin
				// nothing to read outside a readback frame
				io_dout <= '0;
			end
		end
	end

endmodule

//--- rtl/hps_file_loader.sv
// File command decoder turning transfer frames into download write pulses
`timescale 1ns/1ps

module hps_file_loader
	import hps_bus_pkg::*;
	import hps_user_pkg::*;
#(
	parameter int WIDE = 0
) (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  host_word_t  word,
	output file_write_t ioctl,
	output logic        ioctl_download,
	output logic [15:0] ioctl_index,
	output logic [31:0] ioctl_file_ext
);

	// wide mode moves two bytes per data word
	localparam logic [26:0] addr_step = (WIDE != 0) ? 27'd2 : 27'd1;

	logic        file_rec;
	logic [26:0] addr;
	logic [15:0] dat;

	assign file_rec = word.valid && (word.kind == kind_file) && (word.idx != '0);
	assign dat      = (WIDE != 0) ? word.data.raw : {8'h00, word.data.raw[7:0]};

	//////////////////////////////////////////////////
	// file command decode
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ioctl          <= '0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			addr           <= '0;
		end else begin
			// single cycle write strobe
			ioctl.wr <= 1'b0;

			if (file_rec) begin
				case (word.cmd)
					cmd_file_index: ioctl_index <= word.data.raw;
					cmd_file_info: begin
						if (word.idx == 6'd1) begin
							ioctl_file_ext[31:16] <= word.data.raw;
						end else if (word.idx == 6'd2) begin
							ioctl_file_ext[15:0] <= word.data.raw;
						end
					end
					cmd_file_tx: begin
						case (word.idx)
							6'd1: begin
								// nonzero low byte opens a download
								ioctl_download <= (word.data.raw[7:0] != 8'h00);
								addr           <= '0;
							end
							6'd2: addr[15:0]  <= word.data.raw;
							6'd3: addr[26:16] <= word.data.raw[10:0];
							default: ;
						endcase
					end
					cmd_file_dat: begin
						if (ioctl_download) begin
							ioctl.wr   <= 1'b1;
							ioctl.addr <= addr;
							ioctl.dout <= dat;
							addr       <= addr + addr_step;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

//--- rtl/hps_io_top.sv
// Host command port top joining the word framer to the user and file decoders
`timescale 1ns/1ps

module hps_io_top
	import hps_bus_pkg::*;
	import hps_user_pkg::*;
#(
	parameter int WIDE = 0
) (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        io_enable,
	input  logic        fp_enable,
	input  logic        io_strobe,
	input  logic [15:0] io_din,
	input  logic [63:0] status_in,
	input  logic        status_set,
	output logic [15:0] io_dout,
	output core_cfg_t   cfg,
	output player_arr_t players,
	output logic [63:0] status,
	output file_write_t ioctl,
	output logic        ioctl_download,
	output logic [15:0] ioctl_index,
	output logic [31:0] ioctl_file_ext
);

	// framed record shared by both decoders
	host_word_t word;

	hps_word_framer u_framer (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.io_enable (io_enable),
		.fp_enable (fp_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.word      (word)
	);

	hps_user_regs u_user_regs (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.word       (word),
		.status_in  (status_in),
		.status_set (status_set),
		.cfg        (cfg),
		.players    (players),
		.status     (status),
		.io_dout    (io_dout)
	);

	hps_file_loader #(
		.WIDE (WIDE)
	) u_file_loader (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.word           (word),
		.ioctl          (ioctl),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext)
	);

endmodule

//--- testbench/hps_io_asserts.sv
// Protocol assertions on the file loader write strobe and its address sequence
`timescale 1ns/1ps

module hps_io_asserts
	import hps_user_pkg::*;
(
	input logic        clk_sys,
	input logic        arst_n,
	input file_write_t ioctl,
	input logic        ioctl_download
);

	//////////////////////////////////////////////////
	// write strobe rules
	//////////////////////////////////////////////////

	// writes only inside a download
	wr_in_download: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		ioctl.wr |-> ioctl_download
	) else $error("write pulse outside a download");

	// two bytes per back to back write in wide mode
	addr_step: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		(ioctl.wr && $past(ioctl.wr)) |-> (ioctl.addr == $past(ioctl.addr) + 27'd2)
	) else $error("write address did not advance by 2");

	wr_low_after_reset: assert property (
		@(posedge clk_sys) $rose(arst_n) |-> !ioctl.wr
	) else $error("write pulse right after reset release");

endmodule

//--- testbench/hps_io_tb.sv
// Testbench for the host command port running directed frame tests under a watchdog
`timescale 1ns/1ps

module hps_io_tb
	import hps_bus_pkg::*;
	import hps_user_pkg::*;
();

	localparam int clk_period = 40;
	// roughly 30 frames of under 15 cycles each plus a wide margin
	localparam int watchdog_cycles = 3000;

	logic        clk_sys;
	logic        arst_n;
	logic        io_enable;
	logic        fp_enable;
	logic        io_strobe;
	logic [15:0] io_din;
	logic [63:0] status_in;
	logic        status_set;
	logic [15:0] io_dout;
	core_cfg_t   cfg;
	player_arr_t players;
	logic [63:0] status;
	file_write_t ioctl;
	logic        ioctl_download;
	logic [15:0] ioctl_index;
	logic [31:0] ioctl_file_ext;

	int          errors;
	int          tests;
	logic [15:0] fbuf [0:15];
	logic [26:0] wr_addr_q [$];
	logic [15:0] wr_data_q [$];

	hps_io_top #(.WIDE(1)) UUT (.*);

	bind hps_file_loader hps_io_asserts u_asserts (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.ioctl          (ioctl),
		.ioctl_download (ioctl_download)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	// write pulses collected where the outputs are stable
	always @(negedge clk_sys) begin
		if (arst_n && ioctl.wr) begin
			wr_addr_q.push_back(ioctl.addr);
			wr_data_q.push_back(ioctl.dout);
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
		$display("Test failures found");
		$finish;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic note_error(input string what, input logic [63:0] got, input logic [63:0] exp);
		errors++;
		$display("error %0d ns: %s is %h, expected %h", $time, what, got, exp);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		$display("test %s finished with %0d errors", name, errors - errs_before);
	endtask

	// words of fbuf on consecutive strobes, with the frame closed once the last one is decoded
	task automatic send_frame(input logic file_side, input int n);
		@(posedge clk_sys);
		io_enable <= !file_side;
		fp_enable <= file_side;
		for (int i = 0; i < n; i++) begin
			io_strobe <= 1'b1;
			io_din    <= fbuf[i];
			@(posedge clk_sys);
		end
		io_strobe <= 1'b0;
		repeat (2) @(posedge clk_sys);
		io_enable <= 1'b0;
		fp_enable <= 1'b0;
	endtask

	task automatic transfer_ctl(input logic start, input logic [26:0] base);
		fbuf[0] = cmd_file_tx;
		fbuf[1] = start ? 16'h0001 : 16'h0000;
		fbuf[2] = base[15:0];
		fbuf[3] = {5'h00, base[26:16]};
		send_frame(1'b1, start ? 4 : 2);
	endtask

	task automatic pulse_status_set(input logic [63:0] value);
		@(posedge clk_sys);
		status_in  <= value;
		status_set <= 1'b1;
		@(posedge clk_sys);
		status_set <= 1'b0;
		@(posedge clk_sys);
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic test_cfg_joy();
		int          e0;
		core_cfg_t   exp_cfg;
		logic [15:0] joy_cmd [4] = '{cmd_joy0, cmd_joy1, cmd_joy2, cmd_joy3};
		e0 = errors;
		fbuf[0] = cmd_cfg;
		fbuf[1] = 16'($urandom);
		send_frame(1'b0, 2);
		exp_cfg = {fbuf[1][1:0], fbuf[1][4], fbuf[1][10]};
		if (cfg != exp_cfg)
			note_error("cfg", 64'(cfg), 64'(exp_cfg));
		for (int p = 0; p < num_players; p++) begin
			fbuf[0] = joy_cmd[p];
			fbuf[1] = 16'($urandom);
			fbuf[2] = 16'($urandom);
			send_frame(1'b0, 3);
			if (players[p].digital != {fbuf[2], fbuf[1]})
				note_error($sformatf("player %0d digital", p), 64'(players[p].digital),
					64'({fbuf[2], fbuf[1]}));
		end
		finish_test("cfg_joy", e0);
	endtask

	task automatic test_analog();
		int          e0;
		logic [15:0] exp_analog [num_players];
		e0 = errors;
		fbuf[0] = cmd_analog_l;
		for (int s = 0; s < num_players; s++) begin
			fbuf[1] = {12'h000, 4'(s)};
			fbuf[2] = 16'($urandom);
			exp_analog[s] = fbuf[2];
			send_frame(1'b0, 3);
			if (players[s].analog != exp_analog[s])
				note_error($sformatf("player %0d analog", s), 64'(players[s].analog),
					64'(exp_analog[s]));
		end
		// stick index 15 routes axis x to a paddle
		for (int p = 0; p < num_players; p++) begin
			fbuf[1] = {8'h00, 4'(p), 4'hf};
			fbuf[2] = 16'($urandom);
			send_frame(1'b0, 3);
			if (players[p].paddle != fbuf[2][7:0])
				note_error($sformatf("player %0d paddle", p), 64'(players[p].paddle),
					64'(fbuf[2][7:0]));
			if (players[p].analog != exp_analog[p])
				note_error($sformatf("player %0d analog after paddle", p),
					64'(players[p].analog), 64'(exp_analog[p]));
		end
		finish_test("analog", e0);
	endtask

	task automatic test_status();
		int e0;
		e0 = errors;
		fbuf[0] = cmd_status;
		for (int i = 1; i <= 4; i++) begin
			fbuf[i] = 16'($urandom);
		end
		send_frame(1'b0, 5);
		if (status != {fbuf[4], fbuf[3], fbuf[2], fbuf[1]})
			note_error("status", status, {fbuf[4], fbuf[3], fbuf[2], fbuf[1]});
		finish_test("status", e0);
	endtask

	task automatic test_status_req();
		int          e0;
		logic [63:0] last;
		logic [15:0] exp;
		e0 = errors;
		// low nibble keeps the three values apart
		for (int i = 0; i < 3; i++) begin
			last = {32'($urandom), 28'($urandom), 4'(i)};
			pulse_status_set(last);
		end
		@(posedge clk_sys);
		io_enable <= 1'b1;
		for (int k = 0; k <= 4; k++) begin
			io_strobe <= 1'b1;
			io_din    <= (k == 0) ? cmd_status_req : 16'h0000;
			@(posedge clk_sys);
			io_strobe <= 1'b0;
			@(posedge clk_sys);
			@(negedge clk_sys);
			if (k == 0) begin
				exp = 16'h00a3;
			end else begin
				exp = last[(k - 1) * 16 +: 16];
			end
			if (io_dout != exp)
				note_error($sformatf("readback word %0d", k), 64'(io_dout), 64'(exp));
			@(posedge clk_sys);
		end
		io_enable <= 1'b0;
		finish_test("status_req", e0);
	endtask

	task automatic test_download();
		int          e0;
		int          n;
		logic [26:0] base;
		e0 = errors;
		n = 8;
		fbuf[0] = cmd_file_index;
		fbuf[1] = 16'($urandom);
		send_frame(1'b1, 2);
		if (ioctl_index != fbuf[1])
			note_error("ioctl_index", 64'(ioctl_index), 64'(fbuf[1]));
		fbuf[0] = cmd_file_info;
		fbuf[1] = 16'($urandom);
		fbuf[2] = 16'($urandom);
		send_frame(1'b1, 3);
		if (ioctl_file_ext != {fbuf[1], fbuf[2]})
			note_error("ioctl_file_ext", 64'(ioctl_file_ext), 64'({fbuf[1], fbuf[2]}));
		base = 27'($urandom);
		transfer_ctl(1'b1, base);
		if (ioctl_download != 1'b1)
			note_error("ioctl_download after start", 64'(ioctl_download), 64'd1);
		wr_addr_q.delete();
		wr_data_q.delete();
		fbuf[0] = cmd_file_dat;
		for (int i = 1; i <= n; i++) begin
			fbuf[i] = 16'($urandom);
		end
		send_frame(1'b1, n + 1);
		if (wr_addr_q.size() != n)
			note_error("write pulse count", 64'(wr_addr_q.size()), 64'(n));
		for (int i = 0; i < wr_addr_q.size() && i < n; i++) begin
			if (wr_addr_q[i] != base + 27'(2 * i))
				note_error($sformatf("write %0d addr", i), 64'(wr_addr_q[i]),
					64'(base + 27'(2 * i)));
			if (wr_data_q[i] != fbuf[i + 1])
				note_error($sformatf("write %0d dout", i), 64'(wr_data_q[i]), 64'(fbuf[i + 1]));
		end
		transfer_ctl(1'b0, '0);
		if (ioctl_download != 1'b0)
			note_error("ioctl_download after end", 64'(ioctl_download), 64'd0);
		wr_addr_q.delete();
		fbuf[0] = cmd_file_dat;
		send_frame(1'b1, 4);
		if (wr_addr_q.size() != 0)
			note_error("writes after end", 64'(wr_addr_q.size()), 64'd0);
		finish_test("download", e0);
	endtask

	task automatic test_isolation();
		int          e0;
		core_cfg_t   cfg_before;
		player_arr_t players_before;
		logic [63:0] status_before;
		e0 = errors;
		cfg_before     = cfg;
		players_before = players;
		status_before  = status;
		// user commands under fp_enable with data chosen to differ from the registers
		fbuf[0] = cmd_cfg;
		fbuf[1] = {5'h00, ~cfg.direct_video, 5'h00, ~cfg.forced_scandoubler, 2'b00, ~cfg.buttons};
		send_frame(1'b1, 2);
		fbuf[0] = cmd_joy1;
		fbuf[1] = ~players[1].digital[15:0];
		fbuf[2] = ~players[1].digital[31:16];
		send_frame(1'b1, 3);
		fbuf[0] = cmd_status;
		{fbuf[4], fbuf[3], fbuf[2], fbuf[1]} = ~status;
		send_frame(1'b1, 5);
		if (cfg != cfg_before)
			note_error("cfg under fp_enable", 64'(cfg), 64'(cfg_before));
		if (status != status_before)
			note_error("status under fp_enable", status, status_before);
		if (players != players_before) begin
			errors++;
			$display("error %0d ns: player state changed by a frame under fp_enable", $time);
		end
		// file commands under io_enable
		transfer_ctl(1'b1, '0);
		wr_addr_q.delete();
		fbuf[0] = cmd_file_dat;
		send_frame(1'b0, 4);
		fbuf[0] = cmd_file_tx;
		fbuf[1] = 16'h0000;
		send_frame(1'b0, 2);
		if (wr_addr_q.size() != 0)
			note_error("writes under io_enable", 64'(wr_addr_q.size()), 64'd0);
		if (ioctl_download != 1'b1)
			note_error("ioctl_download under io_enable", 64'(ioctl_download), 64'd1);
		transfer_ctl(1'b0, '0);
		// readback word 0 leaves io_dout nonzero until the frame closes
		fbuf[0] = cmd_status_req;
		send_frame(1'b0, 1);
		if (io_dout != 16'h00a3)
			note_error("io_dout before frame close", 64'(io_dout), 64'h00a3);
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		if (io_dout != 16'h0000)
			note_error("io_dout outside frames", 64'(io_dout), 64'd0);
		finish_test("isolation", e0);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		arst_n     = 1'b0;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		errors     = 0;
		tests      = 0;
		void'($urandom(32'h6530));
		repeat (5) @(posedge clk_sys);
		arst_n <= 1'b1;
		@(negedge clk_sys);
		if (ioctl != '0 || ioctl_download || status != '0 || io_dout != '0 ||
		    players != '0 || cfg != '0 || ioctl_index != '0 || ioctl_file_ext != '0)
			note_error("outputs after reset", {ioctl.wr, ioctl_download, 62'(io_dout)}, 64'd0);
		test_cfg_joy();
		test_analog();
		test_status();
		test_status_req();
		test_download();
		test_isolation();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- all.f
rtl/hps_bus_pkg.sv
rtl/hps_user_pkg.sv
rtl/hps_word_framer.sv
rtl/hps_user_regs.sv
rtl/hps_file_loader.sv
rtl/hps_io_top.sv
testbench/hps_io_asserts.sv
testbench/hps_io_tb.sv

//--- Makefile
# Verilator build and run of the host command port testbench
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= hps_io_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
